//--- verilog/acc_dispatch_pkg.sv
// Shared widths and encodings; queue pointer widths assume INSN_QUEUE_DEPTH >= 2
package acc_dispatch_pkg;

  // Operand and result width
  localparam int unsigned XLEN = 32;

  // Transaction IDs cover every scoreboard entry
  localparam int unsigned TRANS_ID_W = 3;
  localparam int unsigned NR_SB_ENTRIES = 8;

  // Instruction queue sizing
  localparam int unsigned INSN_QUEUE_DEPTH = 3;
  localparam int unsigned QUEUE_PTR_W = $clog2(INSN_QUEUE_DEPTH);
  // Usage must also represent a full queue
  localparam int unsigned QUEUE_CNT_W = $clog2(INSN_QUEUE_DEPTH + 1);

  // Load/store counters wrap silently past 7 in flight
  localparam int unsigned ORDER_CNT_W = 3;

  typedef logic [TRANS_ID_W-1:0] trans_id_t;
  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [31:0] insn_t;

  // Functional unit of the issued instruction
  typedef enum logic [2:0] {
    FU_NONE  = 3'd0,
    FU_LOAD  = 3'd1,
    FU_STORE = 3'd2,
    FU_ACCEL = 3'd3,
    FU_ALU   = 3'd4
  } fu_e;

  // Memory class of an accelerator operation
  typedef enum logic [1:0] {
    ACC_OP_OTHER = 2'd0,
    ACC_OP_LOAD  = 2'd1,
    ACC_OP_STORE = 2'd2
  } acc_op_e;

endpackage

//--- verilog/acc_issue_decode.sv
// Stall is combinational from issue inputs; issue_op_q_o is only meaningful while acc_valid_ex_o
module acc_issue_decode import acc_dispatch_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    issue_hs_i,
  input  fu_e     issue_fu_i,
  input  acc_op_e issue_op_i,
  input  logic    issue_ex_valid_i,
  input  logic    flush_unissued_i,
  input  logic    acc_cons_en_i,
  input  logic    queue_ready_i,
  input  logic    no_ld_pending_i,
  input  logic    no_st_pending_i,
  output logic    acc_valid_ex_o,
  output acc_op_e issue_op_q_o,
  output logic    issue_load_o,
  output logic    issue_store_o,
  output logic    issue_stall_o
);

  logic    acc_issue;
  logic    acc_valid_q;
  acc_op_e issue_op_q;

  // Accelerator instruction leaves issue without a prior exception
  assign acc_issue = issue_hs_i && (issue_fu_i == FU_ACCEL) && !issue_ex_valid_i &&
                     !flush_unissued_i;

  // Memory class seen by the load/store counters in the issue cycle
  assign issue_load_o  = acc_issue && (issue_op_i == ACC_OP_LOAD);
  assign issue_store_o = acc_issue && (issue_op_i == ACC_OP_STORE);

  // Execute strobe one cycle after issue
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      acc_valid_q <= 1'b0;
    end else begin
      acc_valid_q <= acc_issue;
    end
  end

  // Op travels alongside the execute strobe into the queue
  always_ff @(posedge clk_i) begin
    if (acc_issue) begin
      issue_op_q <= issue_op_i;
    end
  end

  assign acc_valid_ex_o = acc_valid_q;
  assign issue_op_q_o   = issue_op_q;

  always_comb begin
    case (issue_fu_i)
      // Queue cannot take another entry
      FU_ACCEL: issue_stall_o = !queue_ready_i;
      // Scalar load waits behind accelerator stores
      FU_LOAD:  issue_stall_o = acc_cons_en_i && !no_st_pending_i;
      // Scalar store waits behind any accelerator memory op
      FU_STORE: issue_stall_o = acc_cons_en_i && (!no_st_pending_i || !no_ld_pending_i);
      default:  issue_stall_o = 1'b0;
    endcase
  end

endmodule

//--- verilog/acc_insn_queue.sv
// Push while full and pop while empty are ignored; flush takes priority over a same-cycle push
module acc_insn_queue import acc_dispatch_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      flush_i,
  input  logic      push_i,
  input  insn_t     insn_i,
  input  xlen_t     rs1_i,
  input  xlen_t     rs2_i,
  input  trans_id_t trans_id_i,
  input  acc_op_e   op_i,
  input  logic      pop_i,
  output insn_t     head_insn_o,
  output xlen_t     head_rs1_o,
  output xlen_t     head_rs2_o,
  output trans_id_t head_trans_id_o,
  output acc_op_e   head_op_o,
  output logic      empty_o,
  output logic      ready_o
);

  insn_t     insn_mem [INSN_QUEUE_DEPTH];
  xlen_t     rs1_mem  [INSN_QUEUE_DEPTH];
  xlen_t     rs2_mem  [INSN_QUEUE_DEPTH];
  trans_id_t id_mem   [INSN_QUEUE_DEPTH];
  acc_op_e   op_mem   [INSN_QUEUE_DEPTH];

  logic [QUEUE_PTR_W-1:0] wr_ptr_q;
  logic [QUEUE_PTR_W-1:0] rd_ptr_q;
  logic [QUEUE_CNT_W-1:0] usage_q;
  logic                   do_push;
  logic                   do_pop;

  assign empty_o = (usage_q == '0);
  // Keep one slot spare for the instruction already in execute
  assign ready_o = (usage_q < QUEUE_CNT_W'(INSN_QUEUE_DEPTH - 1));

  assign do_push = push_i && (usage_q != QUEUE_CNT_W'(INSN_QUEUE_DEPTH));
  assign do_pop  = pop_i && !empty_o;

  // Pointers and usage
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      usage_q  <= '0;
    end else begin
      if (do_push) begin
        // Wrap at depth, which need not be a power of two
        wr_ptr_q <= (wr_ptr_q == QUEUE_PTR_W'(INSN_QUEUE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == QUEUE_PTR_W'(INSN_QUEUE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        usage_q <= usage_q + 1'b1;
      end else if (do_pop && !do_push) begin
        usage_q <= usage_q - 1'b1;
      end
    end
  end

  // Entry storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      insn_mem[wr_ptr_q] <= insn_i;
      rs1_mem[wr_ptr_q]  <= rs1_i;
      rs2_mem[wr_ptr_q]  <= rs2_i;
      id_mem[wr_ptr_q]   <= trans_id_i;
      op_mem[wr_ptr_q]   <= op_i;
    end
  end

  // Head read straight from storage
  assign head_insn_o     = insn_mem[rd_ptr_q];
  assign head_rs1_o      = rs1_mem[rd_ptr_q];
  assign head_rs2_o      = rs2_mem[rd_ptr_q];
  assign head_trans_id_o = id_mem[rd_ptr_q];
  assign head_op_o       = op_mem[rd_ptr_q];

endmodule

//--- verilog/acc_spec_tracker.sv
// Flush clears pending IDs only; IDs already committed stay ready until their request is taken
module acc_spec_tracker import acc_dispatch_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      flush_i,
  input  logic      push_i,
  input  trans_id_t push_trans_id_i,
  input  logic      commit_head_accel_i,
  input  logic      commit_head_done_i,
  input  trans_id_t commit_head_trans_id_i,
  input  trans_id_t head_trans_id_i,
  input  logic      req_fire_i,
  input  trans_id_t req_trans_id_i,
  output logic      head_nonspec_o
);

  logic [NR_SB_ENTRIES-1:0] pending_q;
  logic [NR_SB_ENTRIES-1:0] pending_d;
  logic [NR_SB_ENTRIES-1:0] ready_q;
  logic [NR_SB_ENTRIES-1:0] ready_d;
  logic                     commit_ev;
  logic                     commit_hit;

  // Accelerator instruction sits at the window head and has not retired yet
  assign commit_ev  = commit_head_accel_i && !commit_head_done_i;
  // Only IDs the dispatcher actually holds become non-speculative
  assign commit_hit = commit_ev && pending_q[commit_head_trans_id_i];

  always_comb begin
    pending_d = pending_q;
    ready_d   = ready_q;
    // New instruction entering the queue
    if (push_i) begin
      pending_d[push_trans_id_i] = 1'b1;
    end
    // Speculative work is discarded
    if (flush_i) begin
      pending_d = '0;
    end
    // Pending to ready on commit
    if (commit_hit) begin
      pending_d[commit_head_trans_id_i] = 1'b0;
      ready_d[commit_head_trans_id_i]   = 1'b1;
    end
    // Accelerator took the request
    if (req_fire_i) begin
      ready_d[req_trans_id_i] = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
      ready_q   <= '0;
    end else begin
      pending_q <= pending_d;
      ready_q   <= ready_d;
    end
  end

  // Same-cycle commit of the head ID counts too
  assign head_nonspec_o = ready_q[head_trans_id_i] ||
                          (commit_hit && (commit_head_trans_id_i == head_trans_id_i));

endmodule

//--- verilog/acc_req_stage.sv
// One-entry register; an empty stage passes the offer through, a full one blocks new offers
module acc_req_stage import acc_dispatch_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      queue_empty_i,
  input  logic      head_nonspec_i,
  input  insn_t     head_insn_i,
  input  xlen_t     head_rs1_i,
  input  xlen_t     head_rs2_i,
  input  trans_id_t head_trans_id_i,
  input  logic      acc_req_ready_i,
  output logic      pop_o,
  output logic      acc_req_valid_o,
  output insn_t     acc_req_insn_o,
  output xlen_t     acc_req_rs1_o,
  output xlen_t     acc_req_rs2_o,
  output trans_id_t acc_req_trans_id_o
);

  logic      offer;
  logic      full_q;
  insn_t     insn_q;
  xlen_t     rs1_q;
  xlen_t     rs2_q;
  trans_id_t trans_id_q;

  // Head may only leave once non-speculative
  assign offer = !queue_empty_i && head_nonspec_i;
  assign pop_o = offer && !full_q;

  // Held request has priority over the queue head
  assign acc_req_valid_o    = full_q || offer;
  assign acc_req_insn_o     = full_q ? insn_q : head_insn_i;
  assign acc_req_rs1_o      = full_q ? rs1_q : head_rs1_i;
  assign acc_req_rs2_o      = full_q ? rs2_q : head_rs2_i;
  assign acc_req_trans_id_o = full_q ? trans_id_q : head_trans_id_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (full_q) begin
      full_q <= !acc_req_ready_i;
    end else begin
      // Park the popped head while the accelerator is busy
      full_q <= offer && !acc_req_ready_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_o && !acc_req_ready_i) begin
      insn_q     <= head_insn_i;
      rs1_q      <= head_rs1_i;
      rs2_q      <= head_rs2_i;
      trans_id_q <= head_trans_id_i;
    end
  end

endmodule

//--- verilog/acc_order_tracker.sv
// Counters wrap without overflow detection; flush clears only the speculative counts
module acc_order_tracker import acc_dispatch_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    flush_i,
  input  logic    issue_load_i,
  input  logic    issue_store_i,
  input  logic    pop_i,
  input  acc_op_e head_op_i,
  input  logic    load_complete_i,
  input  logic    store_complete_i,
  input  logic    commit_st_barrier_i,
  input  logic    store_pending_i,
  output logic    no_ld_pending_o,
  output logic    no_st_pending_o,
  output logic    ctrl_halt_o
);

  logic [ORDER_CNT_W-1:0] spec_ld_q;
  logic [ORDER_CNT_W-1:0] spec_st_q;
  logic [ORDER_CNT_W-1:0] disp_ld_q;
  logic [ORDER_CNT_W-1:0] disp_st_q;
  logic                   pop_ld;
  logic                   pop_st;
  logic                   halt_q;
  logic                   halt_d;

  // Up/down step shared by all four counters
  function automatic logic [ORDER_CNT_W-1:0] cnt_step(input logic [ORDER_CNT_W-1:0] cnt,
                                                      input logic up,
                                                      input logic down);
    logic [ORDER_CNT_W-1:0] nxt;
    nxt = cnt;
    if (up && !down) begin
      nxt = cnt + 1'b1;
    end else if (down && !up) begin
      nxt = cnt - 1'b1;
    end
    return nxt;
  endfunction

  // Load or store accepted by the request stage
  assign pop_ld = pop_i && (head_op_i == ACC_OP_LOAD);
  assign pop_st = pop_i && (head_op_i == ACC_OP_STORE);

  // Speculative counts, still flushable
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      spec_ld_q <= '0;
      spec_st_q <= '0;
    end else begin
      spec_ld_q <= cnt_step(spec_ld_q, issue_load_i, pop_ld);
      spec_st_q <= cnt_step(spec_st_q, issue_store_i, pop_st);
    end
  end

  // Dispatched counts, retired only by the accelerator
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      disp_ld_q <= '0;
      disp_st_q <= '0;
    end else begin
      disp_ld_q <= cnt_step(disp_ld_q, pop_ld, load_complete_i);
      disp_st_q <= cnt_step(disp_st_q, pop_st, store_complete_i);
    end
  end

  assign no_ld_pending_o = (spec_ld_q == '0) && (disp_ld_q == '0);
  assign no_st_pending_o = (spec_st_q == '0) && (disp_st_q == '0);

  // Barrier sets halt, released once the accelerator drains its stores
  assign halt_d = (halt_q || commit_st_barrier_i) && store_pending_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      halt_q <= 1'b0;
    end else begin
      halt_q <= halt_d;
    end
  end

  assign ctrl_halt_o = halt_q;

endmodule

//--- verilog/acc_dispatcher.sv
// Single commit port; operands must be valid in the cycle acc_valid_ex_o is high
module acc_dispatcher import acc_dispatch_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Issue stage
  input  logic      issue_hs_i,
  input  fu_e       issue_fu_i,
  input  acc_op_e   issue_op_i,
  input  logic      issue_ex_valid_i,
  input  logic      flush_unissued_i,
  input  logic      flush_ex_i,
  input  logic      acc_cons_en_i,
  output logic      issue_stall_o,
  // Execute stage payload
  input  insn_t     insn_i,
  input  xlen_t     operand_a_i,
  input  xlen_t     operand_b_i,
  input  trans_id_t trans_id_i,
  output logic      acc_valid_ex_o,
  // Commit window head
  input  logic      commit_head_accel_i,
  input  logic      commit_head_done_i,
  input  trans_id_t commit_head_trans_id_i,
  input  logic      commit_st_barrier_i,
  output logic      ctrl_halt_o,
  // Accelerator request
  output logic      acc_req_valid_o,
  input  logic      acc_req_ready_i,
  output insn_t     acc_req_insn_o,
  output xlen_t     acc_req_rs1_o,
  output xlen_t     acc_req_rs2_o,
  output trans_id_t acc_req_trans_id_o,
  // Accelerator response
  input  logic      acc_resp_valid_i,
  input  xlen_t     acc_resp_result_i,
  input  trans_id_t acc_resp_trans_id_i,
  input  logic      acc_resp_error_i,
  input  logic      acc_store_pending_i,
  input  logic      acc_load_complete_i,
  input  logic      acc_store_complete_i,
  // Writeback to the core
  output logic      acc_valid_o,
  output xlen_t     acc_result_o,
  output trans_id_t acc_trans_id_o,
  output logic      acc_exception_valid_o
);

  acc_op_e   issue_op_q;
  logic      issue_load;
  logic      issue_store;
  logic      no_ld_pending;
  logic      no_st_pending;
  logic      queue_ready;
  logic      queue_empty;
  logic      queue_pop;
  insn_t     head_insn;
  xlen_t     head_rs1;
  xlen_t     head_rs2;
  trans_id_t head_trans_id;
  acc_op_e   head_op;
  logic      head_nonspec;
  logic      req_fire;

  // Response goes back to the core untouched
  assign acc_valid_o           = acc_resp_valid_i;
  assign acc_result_o          = acc_resp_result_i;
  assign acc_trans_id_o        = acc_resp_trans_id_i;
  assign acc_exception_valid_o = acc_resp_error_i;

  assign req_fire = acc_req_valid_o && acc_req_ready_i;

  acc_issue_decode u_decode (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .issue_hs_i       (issue_hs_i),
    .issue_fu_i       (issue_fu_i),
    .issue_op_i       (issue_op_i),
    .issue_ex_valid_i (issue_ex_valid_i),
    .flush_unissued_i (flush_unissued_i),
    .acc_cons_en_i    (acc_cons_en_i),
    .queue_ready_i    (queue_ready),
    .no_ld_pending_i  (no_ld_pending),
    .no_st_pending_i  (no_st_pending),
    .acc_valid_ex_o   (acc_valid_ex_o),
    .issue_op_q_o     (issue_op_q),
    .issue_load_o     (issue_load),
    .issue_store_o    (issue_store),
    .issue_stall_o    (issue_stall_o)
  );

  // Execute strobe doubles as the queue push
  acc_insn_queue u_queue (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .flush_i         (flush_ex_i),
    .push_i          (acc_valid_ex_o),
    .insn_i          (insn_i),
    .rs1_i           (operand_a_i),
    .rs2_i           (operand_b_i),
    .trans_id_i      (trans_id_i),
    .op_i            (issue_op_q),
    .pop_i           (queue_pop),
    .head_insn_o     (head_insn),
    .head_rs1_o      (head_rs1),
    .head_rs2_o      (head_rs2),
    .head_trans_id_o (head_trans_id),
    .head_op_o       (head_op),
    .empty_o         (queue_empty),
    .ready_o         (queue_ready)
  );

  acc_spec_tracker u_spec (
    .clk_i                  (clk_i),
    .rst_n_i                (rst_n_i),
    .flush_i                (flush_ex_i),
    .push_i                 (acc_valid_ex_o),
    .push_trans_id_i        (trans_id_i),
    .commit_head_accel_i    (commit_head_accel_i),
    .commit_head_done_i     (commit_head_done_i),
    .commit_head_trans_id_i (commit_head_trans_id_i),
    .head_trans_id_i        (head_trans_id),
    .req_fire_i             (req_fire),
    .req_trans_id_i         (acc_req_trans_id_o),
    .head_nonspec_o         (head_nonspec)
  );

  acc_req_stage u_req (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .queue_empty_i      (queue_empty),
    .head_nonspec_i     (head_nonspec),
    .head_insn_i        (head_insn),
    .head_rs1_i         (head_rs1),
    .head_rs2_i         (head_rs2),
    .head_trans_id_i    (head_trans_id),
    .acc_req_ready_i    (acc_req_ready_i),
    .pop_o              (queue_pop),
    .acc_req_valid_o    (acc_req_valid_o),
    .acc_req_insn_o     (acc_req_insn_o),
    .acc_req_rs1_o      (acc_req_rs1_o),
    .acc_req_rs2_o      (acc_req_rs2_o),
    .acc_req_trans_id_o (acc_req_trans_id_o)
  );

  // Pop marks the point a load or store becomes dispatched
  acc_order_tracker u_order (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .flush_i             (flush_ex_i),
    .issue_load_i        (issue_load),
    .issue_store_i       (issue_store),
    .pop_i               (queue_pop),
    .head_op_i           (head_op),
    .load_complete_i     (acc_load_complete_i),
    .store_complete_i    (acc_store_complete_i),
    .commit_st_barrier_i (commit_st_barrier_i),
    .store_pending_i     (acc_store_pending_i),
    .no_ld_pending_o     (no_ld_pending),
    .no_st_pending_o     (no_st_pending),
    .ctrl_halt_o         (ctrl_halt_o)
  );

endmodule

//--- dv/acc_dispatcher_tb.sv
// Stops at the first mismatch; the accelerator is assumed ready outside the back-pressure phase
module acc_dispatcher_tb import acc_dispatch_pkg::*; ();

  localparam int NUM_ENTRIES    = 6;
  localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 40;
  localparam int REQ_WAIT       = 8;

  logic      clk_i;
  logic      rst_n_i;
  logic      issue_hs_i;
  fu_e       issue_fu_i;
  acc_op_e   issue_op_i;
  logic      issue_ex_valid_i;
  logic      flush_unissued_i;
  logic      flush_ex_i;
  logic      acc_cons_en_i;
  logic      issue_stall_o;
  insn_t     insn_i;
  xlen_t     operand_a_i;
  xlen_t     operand_b_i;
  trans_id_t trans_id_i;
  logic      acc_valid_ex_o;
  logic      commit_head_accel_i;
  logic      commit_head_done_i;
  trans_id_t commit_head_trans_id_i;
  logic      commit_st_barrier_i;
  logic      ctrl_halt_o;
  logic      acc_req_valid_o;
  logic      acc_req_ready_i;
  insn_t     acc_req_insn_o;
  xlen_t     acc_req_rs1_o;
  xlen_t     acc_req_rs2_o;
  trans_id_t acc_req_trans_id_o;
  logic      acc_resp_valid_i;
  xlen_t     acc_resp_result_i;
  trans_id_t acc_resp_trans_id_i;
  logic      acc_resp_error_i;
  logic      acc_store_pending_i;
  logic      acc_load_complete_i;
  logic      acc_store_complete_i;
  logic      acc_valid_o;
  xlen_t     acc_result_o;
  trans_id_t acc_trans_id_o;
  logic      acc_exception_valid_o;

  // Stimulus table and the payload drawn for each entry
  acc_op_e     tbl_op    [NUM_ENTRIES];
  trans_id_t   tbl_id    [NUM_ENTRIES];
  logic        tbl_flush [NUM_ENTRIES];
  logic [31:0] exp_insn  [NUM_ENTRIES];
  logic [31:0] exp_rs1   [NUM_ENTRIES];
  logic [31:0] exp_rs2   [NUM_ENTRIES];
  logic [31:0] rng_state;

  acc_dispatcher dut_i (
    .clk_i                  (clk_i),
    .rst_n_i                (rst_n_i),
    .issue_hs_i             (issue_hs_i),
    .issue_fu_i             (issue_fu_i),
    .issue_op_i             (issue_op_i),
    .issue_ex_valid_i       (issue_ex_valid_i),
    .flush_unissued_i       (flush_unissued_i),
    .flush_ex_i             (flush_ex_i),
    .acc_cons_en_i          (acc_cons_en_i),
    .issue_stall_o          (issue_stall_o),
    .insn_i                 (insn_i),
    .operand_a_i            (operand_a_i),
    .operand_b_i            (operand_b_i),
    .trans_id_i             (trans_id_i),
    .acc_valid_ex_o         (acc_valid_ex_o),
    .commit_head_accel_i    (commit_head_accel_i),
    .commit_head_done_i     (commit_head_done_i),
    .commit_head_trans_id_i (commit_head_trans_id_i),
    .commit_st_barrier_i    (commit_st_barrier_i),
    .ctrl_halt_o            (ctrl_halt_o),
    .acc_req_valid_o        (acc_req_valid_o),
    .acc_req_ready_i        (acc_req_ready_i),
    .acc_req_insn_o         (acc_req_insn_o),
    .acc_req_rs1_o          (acc_req_rs1_o),
    .acc_req_rs2_o          (acc_req_rs2_o),
    .acc_req_trans_id_o     (acc_req_trans_id_o),
    .acc_resp_valid_i       (acc_resp_valid_i),
    .acc_resp_result_i      (acc_resp_result_i),
    .acc_resp_trans_id_i    (acc_resp_trans_id_i),
    .acc_resp_error_i       (acc_resp_error_i),
    .acc_store_pending_i    (acc_store_pending_i),
    .acc_load_complete_i    (acc_load_complete_i),
    .acc_store_complete_i   (acc_store_complete_i),
    .acc_valid_o            (acc_valid_o),
    .acc_result_o           (acc_result_o),
    .acc_trans_id_o         (acc_trans_id_o),
    .acc_exception_valid_o  (acc_exception_valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_val(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("[ERROR] %s: got 0x%08h, expected 0x%08h", name, actual, expected));
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic draw_rand(output logic [31:0] v);
    rng_state = xorshift32(rng_state);
    v = rng_state;
  endtask

  // Entry 2 is the flushed one; IDs stay distinct so ready bits never alias
  task automatic load_table();
    tbl_op[0]    = ACC_OP_OTHER;
    tbl_id[0]    = 3'd1;
    tbl_flush[0] = 1'b0;
    tbl_op[1]    = ACC_OP_STORE;
    tbl_id[1]    = 3'd2;
    tbl_flush[1] = 1'b0;
    tbl_op[2]    = ACC_OP_LOAD;
    tbl_id[2]    = 3'd3;
    tbl_flush[2] = 1'b1;
    tbl_op[3]    = ACC_OP_OTHER;
    tbl_id[3]    = 3'd4;
    tbl_flush[3] = 1'b0;
    tbl_op[4]    = ACC_OP_LOAD;
    tbl_id[4]    = 3'd5;
    tbl_flush[4] = 1'b0;
    tbl_op[5]    = ACC_OP_STORE;
    tbl_id[5]    = 3'd6;
    tbl_flush[5] = 1'b0;
  endtask

  // Issue cycle, then the execute cycle carrying the payload
  task automatic issue_accel(input int idx);
    draw_rand(exp_insn[idx]);
    draw_rand(exp_rs1[idx]);
    draw_rand(exp_rs2[idx]);
    @(negedge clk_i);
    issue_hs_i = 1'b1;
    issue_fu_i = FU_ACCEL;
    issue_op_i = tbl_op[idx];
    #1;
    check_val("issue_stall_o", issue_stall_o, 1'b0);
    @(negedge clk_i);
    issue_hs_i  = 1'b0;
    issue_fu_i  = FU_NONE;
    issue_op_i  = ACC_OP_OTHER;
    insn_i      = exp_insn[idx];
    operand_a_i = exp_rs1[idx];
    operand_b_i = exp_rs2[idx];
    trans_id_i  = tbl_id[idx];
    #1;
    check_val("acc_valid_ex_o", acc_valid_ex_o, 1'b1);
    @(negedge clk_i);
    insn_i      = '0;
    operand_a_i = '0;
    operand_b_i = '0;
    #1;
    check_val("acc_valid_ex_o", acc_valid_ex_o, 1'b0);
  endtask

  task automatic drive_commit(input trans_id_t id);
    @(negedge clk_i);
    commit_head_accel_i    = 1'b1;
    commit_head_trans_id_i = id;
    #1;
  endtask

  task automatic release_commit();
    @(negedge clk_i);
    commit_head_accel_i = 1'b0;
    #1;
  endtask

  task automatic wait_req(input int limit);
    int n;
    n = 0;
    while (acc_req_valid_o !== 1'b1) begin
      if (n == limit) begin
        abort_run("No accelerator request appeared after the commit event");
      end
      @(negedge clk_i);
      #1;
      n++;
    end
  endtask

  task automatic check_req(input int idx);
    check_val("acc_req_insn_o", acc_req_insn_o, exp_insn[idx]);
    check_val("acc_req_rs1_o", acc_req_rs1_o, exp_rs1[idx]);
    check_val("acc_req_rs2_o", acc_req_rs2_o, exp_rs2[idx]);
    check_val("acc_req_trans_id_o", acc_req_trans_id_o, tbl_id[idx]);
  endtask

  // Scalar load waits behind stores only, scalar store behind loads and stores
  task automatic check_order(input acc_op_e op);
    logic ld_stall;
    logic st_stall;
    ld_stall = (op == ACC_OP_STORE);
    st_stall = (op != ACC_OP_OTHER);
    @(negedge clk_i);
    acc_cons_en_i = 1'b1;
    issue_fu_i    = FU_LOAD;
    #1;
    check_val("issue_stall_o", issue_stall_o, ld_stall);
    @(negedge clk_i);
    issue_fu_i = FU_STORE;
    #1;
    check_val("issue_stall_o", issue_stall_o, st_stall);
    // Consistency mode off
    @(negedge clk_i);
    acc_cons_en_i = 1'b0;
    #1;
    check_val("issue_stall_o", issue_stall_o, 1'b0);
    @(negedge clk_i);
    issue_fu_i = FU_LOAD;
    #1;
    check_val("issue_stall_o", issue_stall_o, 1'b0);
    if (op != ACC_OP_OTHER) begin
      // Stall holds in the completion cycle and drops after it
      @(negedge clk_i);
      acc_cons_en_i        = 1'b1;
      issue_fu_i           = FU_STORE;
      acc_load_complete_i  = (op == ACC_OP_LOAD);
      acc_store_complete_i = (op == ACC_OP_STORE);
      #1;
      check_val("issue_stall_o", issue_stall_o, 1'b1);
      @(negedge clk_i);
      acc_load_complete_i  = 1'b0;
      acc_store_complete_i = 1'b0;
      #1;
      check_val("issue_stall_o", issue_stall_o, 1'b0);
    end
    @(negedge clk_i);
    acc_cons_en_i = 1'b0;
    issue_fu_i    = FU_NONE;
  endtask

  task automatic send_resp(input int idx);
    logic [31:0] result;
    logic [31:0] err;
    draw_rand(result);
    draw_rand(err);
    @(negedge clk_i);
    acc_resp_valid_i    = 1'b1;
    acc_resp_result_i   = result;
    acc_resp_trans_id_i = tbl_id[idx];
    acc_resp_error_i    = err[0];
    #1;
    check_val("acc_valid_o", acc_valid_o, 1'b1);
    check_val("acc_result_o", acc_result_o, result);
    check_val("acc_trans_id_o", acc_trans_id_o, tbl_id[idx]);
    check_val("acc_exception_valid_o", acc_exception_valid_o, err[0]);
    @(negedge clk_i);
    acc_resp_valid_i = 1'b0;
    acc_resp_error_i = 1'b0;
    #1;
    check_val("acc_valid_o", acc_valid_o, 1'b0);
  endtask

  task automatic run_entry(input int idx);
    issue_accel(idx);
    // Speculative until its commit event
    repeat (2) begin
      @(negedge clk_i);
      #1;
      check_val("acc_req_valid_o", acc_req_valid_o, 1'b0);
    end
    if (tbl_flush[idx]) begin
      @(negedge clk_i);
      flush_ex_i = 1'b1;
      @(negedge clk_i);
      flush_ex_i = 1'b0;
      commit_head_accel_i    = 1'b1;
      commit_head_trans_id_i = tbl_id[idx];
      #1;
      check_val("acc_req_valid_o", acc_req_valid_o, 1'b0);
      release_commit();
      repeat (3) begin
        check_val("acc_req_valid_o", acc_req_valid_o, 1'b0);
        @(negedge clk_i);
        #1;
      end
    end else begin
      drive_commit(tbl_id[idx]);
      wait_req(REQ_WAIT);
      check_req(idx);
      release_commit();
      check_val("acc_req_valid_o", acc_req_valid_o, 1'b0);
      check_order(tbl_op[idx]);
      send_resp(idx);
    end
  endtask

  task automatic run_backpressure();
    int picked [3];
    int n;
    n = 0;
    @(negedge clk_i);
    acc_req_ready_i = 1'b0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (!tbl_flush[i] && n < 3) begin
        picked[n] = i;
        issue_accel(i);
        drive_commit(tbl_id[i]);
        release_commit();
        n++;
      end
    end
    // First request held at the accelerator, the other two fill the queue
    check_val("acc_req_valid_o", acc_req_valid_o, 1'b1);
    check_val("acc_req_trans_id_o", acc_req_trans_id_o, tbl_id[picked[0]]);
    @(negedge clk_i);
    issue_fu_i = FU_ACCEL;
    #1;
    check_val("issue_stall_o", issue_stall_o, 1'b1);
    @(negedge clk_i);
    issue_fu_i      = FU_NONE;
    acc_req_ready_i = 1'b1;
    #1;
    for (int k = 0; k < 3; k++) begin
      wait_req(REQ_WAIT);
      check_req(picked[k]);
      @(negedge clk_i);
      #1;
    end
    check_val("acc_req_valid_o", acc_req_valid_o, 1'b0);
  endtask

  task automatic run_barrier();
    @(negedge clk_i);
    acc_store_pending_i = 1'b1;
    commit_st_barrier_i = 1'b1;
    #1;
    check_val("ctrl_halt_o", ctrl_halt_o, 1'b0);
    @(negedge clk_i);
    commit_st_barrier_i = 1'b0;
    #1;
    check_val("ctrl_halt_o", ctrl_halt_o, 1'b1);
    repeat (2) begin
      @(negedge clk_i);
      #1;
      check_val("ctrl_halt_o", ctrl_halt_o, 1'b1);
    end
    @(negedge clk_i);
    acc_store_pending_i = 1'b0;
    #1;
    check_val("ctrl_halt_o", ctrl_halt_o, 1'b1);
    @(negedge clk_i);
    #1;
    check_val("ctrl_halt_o", ctrl_halt_o, 1'b0);
    // Barrier with nothing pending
    @(negedge clk_i);
    commit_st_barrier_i = 1'b1;
    @(negedge clk_i);
    commit_st_barrier_i = 1'b0;
    #1;
    check_val("ctrl_halt_o", ctrl_halt_o, 1'b0);
  endtask

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    abort_run("Timeout: the test sequence did not finish within the cycle budget");
  end

  initial begin
    rst_n_i                = 1'b0;
    issue_hs_i             = 1'b0;
    issue_fu_i             = FU_NONE;
    issue_op_i             = ACC_OP_OTHER;
    issue_ex_valid_i       = 1'b0;
    flush_unissued_i       = 1'b0;
    flush_ex_i             = 1'b0;
    acc_cons_en_i          = 1'b0;
    insn_i                 = '0;
    operand_a_i            = '0;
    operand_b_i            = '0;
    trans_id_i             = '0;
    commit_head_accel_i    = 1'b0;
    commit_head_done_i     = 1'b0;
    commit_head_trans_id_i = '0;
    commit_st_barrier_i    = 1'b0;
    acc_req_ready_i        = 1'b1;
    acc_resp_valid_i       = 1'b0;
    acc_resp_result_i      = '0;
    acc_resp_trans_id_i    = '0;
    acc_resp_error_i       = 1'b0;
    acc_store_pending_i    = 1'b0;
    acc_load_complete_i    = 1'b0;
    acc_store_complete_i   = 1'b0;
    rng_state              = 32'h7b8c_a281;
    load_table();
    repeat (3) @(negedge clk_i);
    rst_n_i = 1'b1;
    #1;
    check_val("acc_valid_ex_o", acc_valid_ex_o, 1'b0);
    check_val("acc_req_valid_o", acc_req_valid_o, 1'b0);
    check_val("ctrl_halt_o", ctrl_halt_o, 1'b0);
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      run_entry(i);
    end
    run_backpressure();
    run_barrier();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- files.f
verilog/acc_dispatch_pkg.sv
verilog/acc_issue_decode.sv
verilog/acc_insn_queue.sv
verilog/acc_spec_tracker.sv
verilog/acc_req_stage.sv
verilog/acc_order_tracker.sv
verilog/acc_dispatcher.sv
dv/acc_dispatcher_tb.sv
